//--- common/dep_pkg.sv
// deparser layer definitions
package dep_pkg;

  // slot geometry shared by header, metadata and type field
  parameter int SLOT_WIDTH  = 16;
  parameter int HEAD_SLOTS  = 8;
  parameter int META_FIELDS = 4;
  parameter int TAG_WIDTH   = 8;

  // replace slots carried by every rule
  parameter int REP_NUM     = 2;

  typedef logic [$clog2(HEAD_SLOTS)-1:0]  slot_idx_t;
  typedef logic [$clog2(META_FIELDS)-1:0] meta_idx_t;

  // index 0 is the most significant slot in both arrays
  typedef logic [0:HEAD_SLOTS-1][SLOT_WIDTH-1:0]  head_t;
  typedef logic [0:META_FIELDS-1][SLOT_WIDTH-1:0] meta_t;

  // one header slot overwritten by one metadata field
  typedef struct packed {
    logic      en;
    slot_idx_t dst;
    meta_idx_t src;
  } rep_slot_t;

  typedef struct packed {
    slot_idx_t                head_shift;
    rep_slot_t [REP_NUM-1:0]  rep;
  } rule_action_t;

  typedef struct packed {
    logic                  valid;
    logic [SLOT_WIDTH-1:0] type_data;
    logic [SLOT_WIDTH-1:0] type_mask;
    rule_action_t          action;
  } rule_t;

  // config word 0 view
  typedef struct packed {
    logic [SLOT_WIDTH-1:0] type_data;
    logic [SLOT_WIDTH-1:0] type_mask;
  } rule_match_w_t;

  // config word 1 view, action sits just below the valid bit
  typedef struct packed {
    logic                                          valid;
    rule_action_t                                  action;
    logic [2*SLOT_WIDTH-$bits(rule_action_t)-2:0]  pad;
  } rule_act_w_t;

  typedef union packed {
    rule_match_w_t match;
    rule_act_w_t   act;
  } rule_word_u;

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    slot_idx_t            type_off;
    head_t                head;
    meta_t                meta;
    logic [4:0]           spare;
  } dep_beat_t;

  // stage 1 to stage 2 register contents
  typedef struct packed {
    dep_beat_t    beat;
    logic         hit;
    rule_action_t action;
  } stage_t;

endpackage

//--- design/rule_table.sv
// type rule table
`timescale 1ns/1ps

module rule_table import dep_pkg::*; #(
  parameter int RULE_NUM = 8
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_rule_wren,
  input  logic [31:0]          i_rule_addr,
  input  rule_word_u           i_rule_wdata,
  output rule_t [RULE_NUM-1:0] o_rules
);

  localparam int IDX_W = $clog2(RULE_NUM);

  logic [IDX_W-1:0] wr_idx;
  logic             wr_act;

  logic         [RULE_NUM-1:0]                 rule_valid;
  logic         [RULE_NUM-1:0][SLOT_WIDTH-1:0] rule_data;
  logic         [RULE_NUM-1:0][SLOT_WIDTH-1:0] rule_mask;
  rule_action_t [RULE_NUM-1:0]                 rule_action;

  // bit 0 picks the word, the bits above pick the rule
  assign wr_act = i_rule_addr[0];
  assign wr_idx = i_rule_addr[IDX_W:1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rule_valid <= '0;
    end else if (i_rule_wren && wr_act) begin
      // the action word carries the valid flag of the rule
      rule_valid[wr_idx] <= i_rule_wdata.act.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rule_wren) begin
      if (wr_act) begin
        rule_action[wr_idx] <= i_rule_wdata.act.action;
      end else begin
        rule_data[wr_idx] <= i_rule_wdata.match.type_data;
        rule_mask[wr_idx] <= i_rule_wdata.match.type_mask;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RULE_NUM; i++) begin
      o_rules[i].valid     = rule_valid[i];
      o_rules[i].type_data = rule_data[i];
      o_rules[i].type_mask = rule_mask[i];
      o_rules[i].action    = rule_action[i];
    end
  end

endmodule

//--- design/type_lookup.sv
// type field lookup stage
`timescale 1ns/1ps

module type_lookup import dep_pkg::*; #(
  parameter int RULE_NUM = 8
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  dep_beat_t            i_beat,
  input  rule_t [RULE_NUM-1:0] i_rules,
  output logic                 o_valid,
  input  logic                 i_ready,
  output stage_t               o_data
);

  logic [SLOT_WIDTH-1:0] type_field;
  logic [RULE_NUM-1:0]   rule_match;
  logic                  hit;
  rule_action_t          hit_action;
  logic                  load;

  // slot 0 is the top of the header
  assign type_field = i_beat.head[i_beat.type_off];

  // only bits under the mask are compared
  always_comb begin
    for (int i = 0; i < RULE_NUM; i++) begin
      rule_match[i] = i_rules[i].valid &&
        (((type_field ^ i_rules[i].type_data) & i_rules[i].type_mask) == '0);
    end
  end

  // walk down so the lowest matching rule is taken last
  always_comb begin
    hit        = 1'b0;
    hit_action = '0;
    for (int i = RULE_NUM - 1; i >= 0; i--) begin
      if (rule_match[i]) begin
        hit        = 1'b1;
        hit_action = i_rules[i].action;
      end
    end
  end

  // register accepts when empty or draining this cycle
  assign o_ready = !o_valid || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      o_data.beat   <= i_beat;
      o_data.hit    <= hit;
      o_data.action <= hit_action;
    end
  end

endmodule

//--- design/field_replace.sv
// field replace and header shift stage
`timescale 1ns/1ps

module field_replace import dep_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  output logic      o_ready,
  input  stage_t    i_data,
  output logic      o_valid,
  input  logic      i_ready,
  output dep_beat_t o_beat
);

  head_t     head_rep;
  head_t     head_shift;
  dep_beat_t result;
  logic      load;

  // replace slots apply in order, so slot 1 overrides slot 0 on the same target
  always_comb begin
    head_rep = i_data.beat.head;
    if (i_data.hit) begin
      for (int r = 0; r < REP_NUM; r++) begin
        if (i_data.action.rep[r].en) begin
          head_rep[i_data.action.rep[r].dst] =
            i_data.beat.meta[i_data.action.rep[r].src];
        end
      end
    end
  end

  // shift toward slot 0, vacated slots fill with zero
  always_comb begin
    if (i_data.hit) begin
      head_shift = head_rep << (i_data.action.head_shift * SLOT_WIDTH);
    end else begin
      head_shift = head_rep;
    end
  end

  // tag, offset and metadata ride through untouched
  always_comb begin
    result      = i_data.beat;
    result.head = head_shift;
  end

  assign o_ready = !o_valid || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // holds while the consumer stalls
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_beat <= result;
    end
  end

endmodule

//--- design/dep_layer_top.sv
// deparser layer top
`timescale 1ns/1ps

module dep_layer_top import dep_pkg::*; #(
  parameter int RULE_NUM = 8
) (
  input  logic        i_clk,
  input  logic        i_rst_n,
  // rule configuration
  input  logic        i_rule_wren,
  input  logic [31:0] i_rule_addr,
  input  rule_word_u  i_rule_wdata,
  // input beats
  input  logic        i_valid,
  output logic        o_ready,
  input  dep_beat_t   i_beat,
  // output beats
  output logic        o_valid,
  input  logic        i_ready,
  output dep_beat_t   o_beat
);

  rule_t [RULE_NUM-1:0] rules;

  logic   s1_valid;
  logic   s1_ready;
  stage_t s1_data;

  rule_table #(
    .RULE_NUM     (RULE_NUM)
  ) u_rule_table (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_rule_wren  (i_rule_wren),
    .i_rule_addr  (i_rule_addr),
    .i_rule_wdata (i_rule_wdata),
    .o_rules      (rules)
  );

  // stage 1, type match
  type_lookup #(
    .RULE_NUM     (RULE_NUM)
  ) u_type_lookup (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .i_beat       (i_beat),
    .i_rules      (rules),
    .o_valid      (s1_valid),
    .i_ready      (s1_ready),
    .o_data       (s1_data)
  );

  // stage 2, replace and shift
  field_replace u_field_replace (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (s1_valid),
    .o_ready      (s1_ready),
    .i_data       (s1_data),
    .o_valid      (o_valid),
    .i_ready      (i_ready),
    .o_beat       (o_beat)
  );

endmodule

//--- test/dep_ref_model.svh
// deparser reference model
`ifndef DEP_REF_MODEL_SVH
`define DEP_REF_MODEL_SVH

// lowest valid rule whose masked data equals the masked type field
// returns -1 when no rule matches
function automatic int find_rule(input rule_t rules [RULE_NUM], input dep_beat_t b);
  logic [HEAD_SLOTS*SLOT_WIDTH-1:0] flat;
  logic [SLOT_WIDTH-1:0]            field;
  int                               base;
  int                               found;
  flat  = b.head;
  base  = HEAD_SLOTS * SLOT_WIDTH - 1 - SLOT_WIDTH * int'(b.type_off);
  field = flat[base -: SLOT_WIDTH];
  found = -1;
  for (int i = 0; i < RULE_NUM; i++) begin
    if (found < 0 && rules[i].valid &&
        (field & rules[i].type_mask) == (rules[i].type_data & rules[i].type_mask)) begin
      found = i;
    end
  end
  return found;
endfunction

// replace then shift toward slot 0 with zero fill
function automatic dep_beat_t expect_beat(input rule_t rules [RULE_NUM], input dep_beat_t b);
  dep_beat_t    res;
  head_t        h;
  head_t        shifted;
  rule_action_t a;
  int           k;
  res = b;
  k   = find_rule(rules, b);
  if (k >= 0) begin
    a = rules[k].action;
    h = b.head;
    for (int r = 0; r < REP_NUM; r++) begin
      if (a.rep[r].en) begin
        h[a.rep[r].dst] = b.meta[a.rep[r].src];
      end
    end
    for (int s = 0; s < HEAD_SLOTS; s++) begin
      shifted[s] = (s + int'(a.head_shift) < HEAD_SLOTS) ? h[s + int'(a.head_shift)] : '0;
    end
    res.head = shifted;
  end
  return res;
endfunction

`endif

//--- test/tb_dep_layer.sv
// deparser layer testbench
`timescale 1ns/1ps

module tb_dep_layer import dep_pkg::*; ();

  localparam int RULE_NUM    = 8;
  localparam int CYCLE_LIMIT = 2000;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_rule_wren;
  logic [31:0] i_rule_addr;
  rule_word_u  i_rule_wdata;
  logic        i_valid;
  logic        o_ready;
  dep_beat_t   i_beat;
  logic        o_valid;
  logic        i_ready;
  dep_beat_t   o_beat;

  // testbench copy of the rule table
  rule_t     mirror [RULE_NUM];
  dep_beat_t exp_q [$];
  int        cyc_q [$];
  dep_beat_t exp_head;
  int        exp_head_cyc = 0;
  logic      exp_empty = 1'b1;
  logic      check_lat = 1'b0;
  logic      rand_ready = 1'b0;

  int          cyc = 0;
  int          seed = 95;
  int          errors = 0;
  int          err_mark = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [31:0] rnd;

  `include "dep_ref_model.svh"

  dep_layer_top #(.RULE_NUM(RULE_NUM)) uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // scoreboard pops on output transfer then pushes on input transfer
  always @(posedge i_clk) begin
    if (i_rst_n) begin
      if (o_valid && i_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        void'(cyc_q.pop_front());
      end
      if (i_valid && o_ready) begin
        exp_q.push_back(expect_beat(mirror, i_beat));
        cyc_q.push_back(cyc);
      end
      exp_empty = (exp_q.size() == 0);
      if (!exp_empty) begin
        exp_head     = exp_q[0];
        exp_head_cyc = cyc_q[0];
      end
    end
    cyc = cyc + 1;
  end

  initial begin
    wait (cyc >= CYCLE_LIMIT);
    $display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
    $display("Some tests failed");
    $finish;
  end

  a_no_extra: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && i_ready) |-> !exp_empty)
    else begin
      errors++;
      $display("output beat arrived while no beat was expected");
    end

  a_beat_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && i_ready && !exp_empty) |-> (o_beat == exp_head))
    else begin
      errors++;
      $display("Error: o_beat expected %h got %h", $sampled(exp_head), $sampled(o_beat));
    end

  a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_beat)))
    else begin
      errors++;
      $display("Error: o_beat changed under stall, was %h now %h", $past(o_beat),
               $sampled(o_beat));
    end

  a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (check_lat && o_valid && i_ready && !exp_empty) |-> (cyc - exp_head_cyc == 2))
    else begin
      errors++;
      $display("beat left %0d cycles after its input instead of 2",
               $sampled(cyc) - $sampled(exp_head_cyc));
    end

  function automatic rule_action_t make_action(input slot_idx_t shift, input rep_slot_t r0,
                                               input rep_slot_t r1);
    rule_action_t a;
    a.head_shift = shift;
    a.rep[0]     = r0;
    a.rep[1]     = r1;
    return a;
  endfunction

  task write_word(input logic [31:0] addr, input rule_word_u w);
    i_rule_wren  = 1'b1;
    i_rule_addr  = addr;
    i_rule_wdata = w;
    @(negedge i_clk);
    i_rule_wren  = 1'b0;
  endtask

  // bit 0 of words writes the match word and bit 1 the action word
  task write_rule(input int idx, input logic [15:0] data, input logic [15:0] mask,
                  input rule_action_t act, input logic [1:0] words);
    rule_word_u w;
    if (words[0]) begin
      w = '0;
      w.match.type_data = data;
      w.match.type_mask = mask;
      write_word(32'(idx * 2), w);
      mirror[idx].type_data = data;
      mirror[idx].type_mask = mask;
    end
    if (words[1]) begin
      w = '0;
      w.act.valid  = 1'b1;
      w.act.action = act;
      write_word(32'(idx * 2 + 1), w);
      mirror[idx].valid  = 1'b1;
      mirror[idx].action = act;
    end
  endtask

  task pick_ready;
    if (rand_ready) begin
      rnd     = $random(seed);
      i_ready = rnd[0];
    end
  endtask

  // sel 0 keeps a random type field
  task build_beat(input int sel, output dep_beat_t b);
    b.head     = {$random(seed), $random(seed), $random(seed), $random(seed)};
    b.meta     = {$random(seed), $random(seed)};
    rnd        = $random(seed);
    b.tag      = rnd[7:0];
    b.type_off = rnd[10:8];
    b.spare    = '0;
    case (sel)
      1: b.head[b.type_off] = 16'h88a8;
      2: b.head[b.type_off] = 16'h8123;
      3: b.head[b.type_off] = 16'h8a55;
      4: b.head[b.type_off] = 16'h0800;
      5: b.head[b.type_off] = 16'h9abc;
      default: ;
    endcase
  endtask

  task send_beat(input int sel);
    dep_beat_t b;
    logic      done;
    build_beat(sel, b);
    done    = 1'b0;
    i_beat  = b;
    i_valid = 1'b1;
    while (!done) begin
      pick_ready();
      @(posedge i_clk);
      done = o_ready;
      @(negedge i_clk);
    end
    i_valid = 1'b0;
  endtask

  task drain;
    while (exp_q.size() != 0) begin
      pick_ready();
      @(negedge i_clk);
    end
  endtask

  task end_test(input int num, input string name);
    if (errors == err_mark) begin
      n_pass++;
      $display("test %0d %s: ok", num, name);
    end else begin
      n_fail++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    i_rst_n      = 1'b0;
    i_rule_wren  = 1'b0;
    i_rule_addr  = '0;
    i_rule_wdata = '0;
    i_valid      = 1'b0;
    i_beat       = '0;
    // consumer stalled so o_ready reflects only the empty stages
    i_ready      = 1'b0;
    foreach (mirror[i]) mirror[i] = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);

    assert (!o_valid) else begin
      errors++;
      $display("Error: o_valid expected 0 got %h", o_valid);
    end
    assert (o_ready) else begin
      errors++;
      $display("Error: o_ready expected 1 got %h", o_ready);
    end
    i_ready = 1'b1;
    repeat (3) send_beat(0);
    drain();
    end_test(1, "reset and empty table");

    write_rule(0, 16'h88a8, 16'hffff, make_action(3'd0, {1'b1, 3'd2, 2'd1},
               {1'b1, 3'd5, 2'd3}), 2'b11);
    send_beat(1);
    send_beat(4);
    drain();
    end_test(2, "exact match replace");

    // rules 1 and 2 overlap on 0x81xx
    write_rule(1, 16'h8100, 16'hff00, make_action(3'd2, {1'b1, 3'd0, 2'd0}, 6'd0), 2'b11);
    write_rule(2, 16'h8000, 16'hf000, make_action(3'd3, 6'd0, {1'b1, 3'd7, 2'd2}), 2'b11);
    send_beat(2);
    send_beat(3);
    send_beat(1);
    drain();
    end_test(3, "priority and shift");

    check_lat = 1'b1;
    repeat (10) begin
      rnd = $random(seed);
      send_beat(int'(rnd[1:0]));
    end
    drain();
    check_lat = 1'b0;
    end_test(4, "back to back latency");

    rand_ready = 1'b1;
    repeat (60) begin
      rnd = $random(seed);
      send_beat(int'(rnd[1:0]));
    end
    drain();
    rand_ready = 1'b0;
    i_ready    = 1'b1;
    end_test(5, "random back-pressure");

    // action word of rule 0 and match word of rule 2 only
    write_rule(0, 16'h0, 16'h0, make_action(3'd1, {1'b1, 3'd4, 2'd2}, 6'd0), 2'b10);
    write_rule(2, 16'h9abc, 16'hffff, '0, 2'b01);
    send_beat(1);
    send_beat(5);
    send_beat(3);
    send_beat(2);
    drain();
    end_test(6, "rule rewrite");

    $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+test
common/dep_pkg.sv
design/rule_table.sv
design/type_lookup.sv
design/field_replace.sv
design/dep_layer_top.sv
test/tb_dep_layer.sv
